// ==== verilog.f ====
common/uart_cfg_pkg.sv
common/uart_msg_pkg.sv
uart/uart_tx.sv
uart/uart_rx.sv
hdl/cmd_splitter.sv
hdl/uart_bridge.sv
test/tb_clkgen.sv
test/tb_checker.sv
test/tb_uart_bridge.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the uart bridge testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/10ps \
  -f verilog.f --top-module tb_uart_bridge -o sim_uart_bridge

./obj_dir/sim_uart_bridge > sim.log 2>&1
cat sim.log

if grep -q "TB FAILED" sim.log; then
  echo "simulation reported failure"
  exit 1
fi
echo "simulation finished without failure"

// ==== test/tb_uart_bridge.sv ====
`timescale 1ns/10ps

module tb_uart_bridge;

  import uart_cfg_pkg::*;
  import uart_msg_pkg::*;

  localparam int n_cmds = 12;
  localparam int n_rx   = 12;
  localparam int timeout_cycles = (n_cmds + n_rx) * 24 * int'(bit_cycles) + 2000;

  logic     clk;
  logic     rst_n;
  cmd_t     cmd_in;
  logic     cmd_vld;
  logic     cmd_rdy;
  logic     tx;
  logic     rx;
  rx_word_t read_data;
  logic     read_rdy;
  int       cyc = 0;
  int       total_err;

  tb_clkgen u_clkgen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  uart_bridge UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .tx        (tx),
    .rx        (rx),
    .read_data (read_data),
    .read_rdy  (read_rdy)
  );

  tb_checker u_checker (
    .clk       (clk),
    .rst_n     (rst_n),
    .cyc       (cyc),
    .tx        (tx),
    .cmd_rdy   (cmd_rdy),
    .cmd_vld   (cmd_vld),
    .cmd_in    (cmd_in),
    .read_rdy  (read_rdy),
    .read_data (read_data)
  );

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= timeout_cycles) begin
      $display("ERROR %0t run did not finish within %0d cycles", $time, timeout_cycles);
      $display("errors: %0d value, %0d other",
               u_checker.n_value_err, u_checker.n_other_err + 1);
      $display("TB FAILED");
      $finish;
    end
  end

  task automatic send_commands();
    int i;
    for (i = 0; i < n_cmds; i++) begin
      @(posedge clk);
      #2;
      cmd_in = 16'($urandom);
      cmd_vld = 1'b1;
      // held until the bridge is ready again
      @(negedge clk);
      while (!cmd_rdy) @(negedge clk);
      @(posedge clk);
      #2;
      cmd_vld = 1'b0;
      if (i % 2 == 1) begin
        // bridge busy, this one must be dropped
        repeat ($urandom_range(3000, 20)) @(posedge clk);
        #2;
        cmd_in = 16'($urandom);
        cmd_vld = 1'b1;
        @(posedge clk);
        #2;
        cmd_vld = 1'b0;
      end
      repeat ($urandom_range(300, 0)) @(posedge clk);
    end
    @(negedge clk);
    while (!cmd_rdy) @(negedge clk);
  endtask

  task automatic drive_rx_frame(input logic [10:0] f);
    logic [10:0] sh;
    int          k;
    sh = f;
    for (k = 0; k < int'(frame_bits); k++) begin
      @(posedge clk);
      #2;
      rx = sh[0];
      sh = sh >> 1;
      if (k == 0) u_checker.expect_rx(f, cyc);
      repeat (bit_cycles - 1) @(posedge clk);
    end
  endtask

  task automatic send_rx_frames();
    int          i;
    logic [7:0]  b;
    logic [10:0] f;
    for (i = 0; i < n_rx; i++) begin
      b = 8'($urandom);
      f = u_checker.frame_of(b);
      // every fourth frame carries bad parity
      if (i % 4 == 2) f[9] = ~f[9];
      repeat ($urandom_range(600, 1)) @(posedge clk);
      drive_rx_frame(f);
    end
  endtask

  initial begin
    void'($urandom(32'h39b2_dc9a));
    cmd_in = '0;
    cmd_vld = 1'b0;
    rx = 1'b1;
    wait (rst_n);
    fork
      send_commands();
      send_rx_frames();
    join
    repeat (20) @(negedge clk);
    u_checker.check_drained();
    total_err = u_checker.n_value_err + u_checker.n_other_err;
    $display("errors: %0d value, %0d other", u_checker.n_value_err, u_checker.n_other_err);
    if (total_err == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== test/tb_checker.sv ====
`timescale 1ns/10ps

module tb_checker (
  input logic                   clk,
  input logic                   rst_n,
  input int                     cyc,
  input logic                   tx,
  input logic                   cmd_rdy,
  input logic                   cmd_vld,
  input uart_msg_pkg::cmd_t     cmd_in,
  input logic                   read_rdy,
  input uart_msg_pkg::rx_word_t read_data
);

  import uart_cfg_pkg::*;
  import uart_msg_pkg::*;

  // 10.5 bit times from start edge to the stop-bit sample
  localparam int rx_latency = int'(21 * bit_cycles / 2);
  localparam int rx_slack   = 3;
  // two frames, two cycles of lead-in, four of turnaround
  localparam int rdy_low_cycles = int'(2 + 2 * frame_bits * bit_cycles + 4);

  typedef struct packed {
    logic [10:0] frame;
    int          start;
  } rx_exp_t;

  int          n_value_err = 0;
  int          n_other_err = 0;
  int          n_accepted = 0;
  logic [7:0]  tx_exp_q[$];
  rx_exp_t     rx_exp_q[$];
  logic        rdy_pending = 1'b0;
  int          rdy_rise_at = 0;
  logic        reset_seen = 1'b0;

  // line image of a byte: start, data lsb first, odd parity, stop
  function automatic logic [10:0] frame_of(input logic [7:0] b);
    logic [7:0] d;
    int         ones;
    int         i;
    logic       par;
    d = b;
    ones = 0;
    for (i = 0; i < 8; i++) begin
      if (d[0]) ones++;
      d = d >> 1;
    end
    // parity bit makes the total count odd
    par = (ones % 2 == 0);
    return {1'b1, par, b, 1'b0};
  endfunction

  // data plus parity holding an even count of ones is an error
  function automatic logic parity_err_of(input logic [10:0] f);
    logic [8:0] d;
    int         ones;
    int         i;
    d = f[9:1];
    ones = 0;
    for (i = 0; i < 9; i++) begin
      if (d[0]) ones++;
      d = d >> 1;
    end
    return (ones % 2 == 0);
  endfunction

  task automatic expect_rx(input logic [10:0] f, input int start);
    rx_exp_t e;
    e.frame = f;
    e.start = start;
    rx_exp_q.push_back(e);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] got_v);
    $display("FAIL %0t %s exp %0h got %0h", $time, name, exp_v, got_v);
    n_value_err++;
  endtask

  task automatic report_problem(input string msg);
    $display("ERROR %0t %s", $time, msg);
    n_other_err++;
  endtask

  task automatic check_drained();
    if (tx_exp_q.size() != 0)
      report_problem($sformatf("%0d command bytes never went out on tx", tx_exp_q.size()));
    if (rx_exp_q.size() != 0)
      report_problem($sformatf("%0d rx frames never gave a read_rdy", rx_exp_q.size()));
    if (n_accepted == 0)
      report_problem("no command was ever accepted");
  endtask

  // tx frames, sampled mid-bit after each falling start edge
  initial begin : tx_decode
    logic [10:0] got;
    logic [7:0]  want;
    int          k;
    forever begin
      @(negedge clk);
      if (rst_n && !tx) begin
        got = '0;
        repeat (half_bit_cycles) @(negedge clk);
        got = {tx, got[10:1]};
        for (k = 1; k < int'(frame_bits); k++) begin
          repeat (bit_cycles) @(negedge clk);
          got = {tx, got[10:1]};
        end
        if (tx_exp_q.size() == 0) begin
          report_problem("frame on tx with no accepted command behind it");
        end else begin
          want = tx_exp_q.pop_front();
          if (got !== frame_of(want))
            report_mismatch("tx frame", 32'(frame_of(want)), 32'(got));
        end
      end
    end
  end

  always @(negedge clk) begin : watch
    rx_exp_t    e;
    logic       exp_rdy;
    logic [8:0] want;
    logic [8:0] got;
    int         lat;
    if (rst_n) begin
      if (!reset_seen) begin
        reset_seen = 1'b1;
        if (tx !== 1'b1)
          report_mismatch("tx", 32'(1'b1), 32'(tx));
      end
      exp_rdy = !(rdy_pending && cyc < rdy_rise_at);
      if (rdy_pending && cyc >= rdy_rise_at) rdy_pending = 1'b0;
      if (cmd_rdy !== exp_rdy)
        report_mismatch("cmd_rdy", 32'(exp_rdy), 32'(cmd_rdy));
      // next rising edge takes the command
      if (cmd_vld && cmd_rdy) begin
        tx_exp_q.push_back(cmd_in.hi);
        tx_exp_q.push_back(cmd_in.lo);
        n_accepted++;
        rdy_pending = 1'b1;
        rdy_rise_at = cyc + 1 + rdy_low_cycles;
      end
      if (read_rdy) begin
        if (rx_exp_q.size() == 0) begin
          report_problem("read_rdy pulsed with no rx frame sent");
        end else begin
          e = rx_exp_q.pop_front();
          want = {parity_err_of(e.frame), e.frame[8:1]};
          got = read_data;
          if (got !== want)
            report_mismatch("read_data", 32'(want), 32'(got));
          lat = cyc - e.start;
          if (lat < rx_latency - rx_slack || lat > rx_latency + rx_slack)
            report_problem($sformatf("read_rdy came %0d cycles after the start edge, not %0d",
                                     lat, rx_latency));
        end
      end
    end
  end

endmodule

// ==== test/tb_clkgen.sv ====
`timescale 1ns/10ps

module tb_clkgen (
  output logic clk,
  output logic rst_n
);

  localparam int period_ns    = 20;
  localparam int reset_cycles = 16;

  initial begin
    clk = 1'b0;
    forever #(period_ns / 2) clk = ~clk;
  end

  // release a little after the edge, like every other input
  initial begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    #2;
    rst_n = 1'b1;
  end

endmodule

// ==== hdl/uart_bridge.sv ====
`timescale 1ns/10ps

module uart_bridge (
  input  logic                   clk,
  input  logic                   rst_n,
  input  uart_msg_pkg::cmd_t     cmd_in,
  input  logic                   cmd_vld,
  output logic                   cmd_rdy,
  output logic                   tx,
  input  logic                   rx,
  output uart_msg_pkg::rx_word_t read_data,
  output logic                   read_rdy
);

  import uart_cfg_pkg::*;

  logic [data_bits-1:0] tx_byte;
  logic                 tx_load;
  logic                 tx_done;

  cmd_splitter u_splitter (
    .clk     (clk),
    .rst_n   (rst_n),
    .cmd_in  (cmd_in),
    .cmd_vld (cmd_vld),
    .cmd_rdy (cmd_rdy),
    .tx_byte (tx_byte),
    .tx_load (tx_load),
    .tx_done (tx_done)
  );

  uart_tx u_tx (
    .clk     (clk),
    .rst_n   (rst_n),
    .tx_byte (tx_byte),
    .tx_load (tx_load),
    .tx_done (tx_done),
    .tx      (tx)
  );

  // receive side runs on its own
  uart_rx u_rx (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx        (rx),
    .read_data (read_data),
    .read_rdy  (read_rdy)
  );

endmodule

// ==== hdl/cmd_splitter.sv ====
`timescale 1ns/10ps

module cmd_splitter (
  input  logic                              clk,
  input  logic                              rst_n,
  input  uart_msg_pkg::cmd_t                cmd_in,
  input  logic                              cmd_vld,
  output logic                              cmd_rdy,
  output logic [uart_cfg_pkg::data_bits-1:0] tx_byte,
  output logic                              tx_load,
  input  logic                              tx_done
);

  import uart_msg_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_hi,
    st_lo
  } split_state_t;

  split_state_t state;
  cmd_t         cmd_q;
  logic         accept;

  assign accept = cmd_vld & cmd_rdy;

  // held for both frames
  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_q <= cmd_in;
    end
  end

  assign tx_byte = (state == st_lo) ? cmd_q.lo : cmd_q.hi;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= st_idle;
      cmd_rdy <= 1'b1;
      tx_load <= 1'b0;
    end else begin
      tx_load <= 1'b0;
      case (state)
        st_idle: begin
          if (accept) begin
            state   <= st_hi;
            cmd_rdy <= 1'b0;
            tx_load <= 1'b1;
          end
        end
        st_hi: begin
          // transmitter just went idle
          if (tx_done) begin
            state   <= st_lo;
            tx_load <= 1'b1;
          end
        end
        st_lo: begin
          if (tx_done) begin
            state   <= st_idle;
            cmd_rdy <= 1'b1;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

// ==== uart/uart_rx.sv ====
`timescale 1ns/10ps

module uart_rx (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   rx,
  output uart_msg_pkg::rx_word_t read_data,
  output logic                   read_rdy
);

  import uart_cfg_pkg::*;

  typedef enum logic [1:0] {
    rx_idle,
    rx_start,
    rx_data,
    rx_stop
  } rx_state_t;

  rx_state_t             state;
  logic                  rx_meta;
  logic                  rx_s;
  logic                  rx_prev;
  logic [baud_cnt_w-1:0] baud_cnt;
  logic [bit_cnt_w-1:0]  bit_cnt;
  logic [data_bits:0]    shift_q;
  logic                  fall;
  logic                  half_hit;
  logic                  bit_hit;
  logic                  sample;

  assign fall     = rx_prev & ~rx_s;
  assign half_hit = (baud_cnt == baud_cnt_w'(half_bit_cycles - 1));
  assign bit_hit  = (baud_cnt == baud_cnt_w'(bit_cycles - 1));
  assign sample   = (state == rx_data) && bit_hit;

  // two-flop synchronizer plus edge history
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_s    <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_s    <= rx_meta;
      rx_prev <= rx_s;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= rx_idle;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      read_rdy <= 1'b0;
    end else begin
      read_rdy <= 1'b0;
      case (state)
        rx_idle: begin
          if (fall) begin
            state    <= rx_start;
            // edge detect already cost one cycle
            baud_cnt <= baud_cnt_w'(1);
          end
        end
        rx_start: begin
          if (half_hit) begin
            baud_cnt <= '0;
            bit_cnt  <= '0;
            // line back high at mid-bit is a glitch
            state    <= rx_s ? rx_idle : rx_data;
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        rx_data: begin
          if (bit_hit) begin
            baud_cnt <= '0;
            if (bit_cnt == bit_cnt_w'(data_bits)) begin
              state <= rx_stop;
            end else begin
              bit_cnt <= bit_cnt + 1'b1;
            end
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        rx_stop: begin
          if (bit_hit) begin
            baud_cnt <= '0;
            read_rdy <= 1'b1;
            state    <= rx_idle;
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        default: state <= rx_idle;
      endcase
    end
  end

  // data lsb first, parity lands in the top bit
  always_ff @(posedge clk) begin
    if (sample) begin
      shift_q <= {rx_s, shift_q[data_bits:1]};
    end
    if ((state == rx_stop) && bit_hit) begin
      read_data.data       <= shift_q[data_bits-1:0];
      // even count of ones over data and parity
      read_data.parity_err <= ~^shift_q;
    end
  end

endmodule

// ==== uart/uart_tx.sv ====
`timescale 1ns/10ps

module uart_tx (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic [uart_cfg_pkg::data_bits-1:0] tx_byte,
  input  logic                              tx_load,
  output logic                              tx_done,
  output logic                              tx
);

  import uart_cfg_pkg::*;

  logic [frame_bits-1:0] shift_q;
  logic [baud_cnt_w-1:0] baud_cnt;
  logic [bit_cnt_w-1:0]  bit_cnt;
  logic                  busy;
  logic                  frame_end;
  logic                  baud_wrap;
  logic                  last_bit;

  assign baud_wrap = (baud_cnt == baud_cnt_w'(bit_cycles - 1));
  assign last_bit  = (bit_cnt == bit_cnt_w'(frame_bits - 1));

  // baud and bit counters
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy      <= 1'b0;
      baud_cnt  <= '0;
      bit_cnt   <= '0;
      frame_end <= 1'b0;
      tx_done   <= 1'b0;
    end else begin
      frame_end <= 1'b0;
      // tx is one register behind the shifter, so is tx_done
      tx_done   <= frame_end;
      if (tx_load) begin
        busy     <= 1'b1;
        baud_cnt <= '0;
        bit_cnt  <= '0;
      end else if (busy) begin
        if (baud_wrap) begin
          baud_cnt <= '0;
          if (last_bit) begin
            busy      <= 1'b0;
            frame_end <= 1'b1;
          end else begin
            bit_cnt <= bit_cnt + 1'b1;
          end
        end else begin
          baud_cnt <= baud_cnt + 1'b1;
        end
      end
    end
  end

  // frame shifter, fills with ones so the line idles high
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      shift_q <= '1;
      tx      <= 1'b1;
    end else begin
      if (tx_load) begin
        // stop, odd parity, data lsb first, start
        shift_q <= {1'b1, ~^tx_byte, tx_byte, 1'b0};
      end else if (busy && baud_wrap) begin
        shift_q <= {1'b1, shift_q[frame_bits-1:1]};
      end
      tx <= shift_q[0];
    end
  end

endmodule

// ==== common/uart_msg_pkg.sv ====
package uart_msg_pkg;

  // host command word
  localparam int unsigned cmd_width = 16;

  // high byte goes out first
  typedef struct packed {
    logic [cmd_width/2-1:0] hi;
    logic [cmd_width/2-1:0] lo;
  } cmd_t;

  // received byte and its parity check result
  typedef struct packed {
    logic       parity_err;
    logic [7:0] data;
  } rx_word_t;

endpackage

// ==== common/uart_cfg_pkg.sv ====
package uart_cfg_pkg;

  // system clock and line rate
  localparam int unsigned clk_freq  = 50_000_000;
  localparam int unsigned baud_rate = 115_200;

  // clock cycles per bit on the line
  localparam int unsigned bit_cycles = clk_freq / baud_rate;

  // offset from the start edge to the first mid-bit sample
  localparam int unsigned half_bit_cycles = bit_cycles / 2;

  // frame format: start, data, odd parity, stop
  localparam int unsigned data_bits  = 8;
  localparam int unsigned frame_bits = data_bits + 3;

  // counter widths
  localparam int unsigned bit_cnt_w  = $clog2(frame_bits + 1);
  localparam int unsigned baud_cnt_w = $clog2(bit_cycles);

endpackage
